// ==== Bender.yml ====
package:
  name: cpu8051_subset

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/cpu_pkg.sv
      - design/cpu_decoder.sv
      - design/cpu_alu.sv
      - design/cpu_bus_master.sv
      - design/cpu_control.sv
      - design/cpu_top.sv

  - target: test
    include_dirs:
      - design
    files:
      - tb/cpu_tb_mem.sv
      - tb/tb_cpu.sv

// ==== design/cpu_alu.sv ====
/*
 * Execute unit
 * 8-bit pass, add, and, xor and increment with carry and parity
 */
`timescale 1ns/100ps
`default_nettype none

module cpu_alu (
    input  cpu_pkg::byte_t   a,
    input  cpu_pkg::byte_t   b,
    input  cpu_pkg::alu_op_t op,
    input  logic             carry_in,
    output cpu_pkg::byte_t   result,
    output logic             carry_out,
    output logic             parity
);
    import cpu_pkg::*;

    always_comb begin
        carry_out = carry_in;   // only ADD touches the carry
        case (op)
            ALU_ADD: {carry_out, result} = {1'b0, a} + {1'b0, b};
            ALU_ANL: result = a & b;
            ALU_XRL: result = a ^ b;
            ALU_INC: result = a + 8'd1;     // no carry out, as on the 8051
            default: result = b;            // pass
        endcase
    end

    assign parity = ^result;    // even parity over the result

endmodule

`default_nettype wire

// ==== design/cpu_bus_master.sv ====
/*
 * Wishbone classic master
 * runs one single read or write cycle per request and
 * returns the read byte with a one-cycle done pulse
 */
`timescale 1ns/100ps
`default_nettype none

module cpu_bus_master (
    input  logic           clk,
    input  logic           rst_n,
    // request side
    input  logic           req,
    input  logic           req_we,
    input  logic           req_ram_sel,
    input  cpu_pkg::addr_t req_adr,
    input  cpu_pkg::byte_t req_wdata,
    output logic           done,
    output cpu_pkg::byte_t rdata,
    // wishbone side
    output cpu_pkg::addr_t wb_adr,
    output cpu_pkg::byte_t wb_dat_o,
    input  cpu_pkg::byte_t wb_dat_i,
    output logic           wb_we,
    output logic           wb_cyc,
    output logic           wb_stb,
    output logic           ram_sel,
    input  logic           wb_ack
);

    // ----------------------------------------------------------
    // cycle control
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            wb_we  <= 1'b0;
            done   <= 1'b0;
        end else begin
            done <= 1'b0;
            if (wb_cyc) begin
                if (wb_ack) begin   // slave may stretch this any number of cycles
                    wb_cyc <= 1'b0;
                    wb_stb <= 1'b0;
                    wb_we  <= 1'b0;
                    done   <= 1'b1;
                end
            end else if (req) begin
                wb_cyc <= 1'b1;
                wb_stb <= 1'b1;
                wb_we  <= req_we;
            end
        end
    end

    // address, data and tag held for the whole cycle
    always_ff @(posedge clk) begin
        if (req && !wb_cyc) begin
            wb_adr   <= req_adr;
            wb_dat_o <= req_wdata;
            ram_sel  <= req_ram_sel;
        end
        if (wb_cyc && wb_ack) begin
            rdata <= wb_dat_i;  // sampled at the ack edge
        end
    end

endmodule

`default_nettype wire

// ==== design/cpu_config.svh ====
/*
 * 8051 subset core constants
 * widths, reset vector, idle length, SFR addresses and PSW bits
 */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

`define CPU_DATA_W      8
`define CPU_ADDR_W      16
`define CPU_RESET_PC    16'h0100    // first fetch after reset
`define CPU_NOP_CYCLES  3'd4        // idle cycles per NOP

// SFRs served inside the core
`define CPU_SFR_ACC     8'hE0
`define CPU_SFR_B       8'hF0
`define CPU_SFR_PSW     8'hD0

`define CPU_PSW_CY      7           // carry from ADD
`define CPU_PSW_P       0           // accumulator parity

`endif

// ==== design/cpu_control.sv ====
/*
 * Instruction control FSM
 * holds PC, IR, ACC, B, PSW and the operand registers, runs fetch,
 * operand and write-back stages and serves ACC/B/PSW internally
 */
`timescale 1ns/100ps
`default_nettype none

`include "cpu_config.svh"

module cpu_control (
    input  logic                  clk,
    input  logic                  rst_n,
    // decoder
    input  cpu_pkg::cpu_state_t   next_state,
    input  logic [1:0]            step_total,
    input  cpu_pkg::alu_op_t      alu_op,
    input  cpu_pkg::operand_src_t dst_src,
    input  cpu_pkg::operand_src_t b_src,
    output cpu_pkg::byte_t        opcode,
    output logic [1:0]            step,
    // ALU
    output cpu_pkg::byte_t        alu_a,
    output cpu_pkg::byte_t        alu_b,
    output cpu_pkg::alu_op_t      alu_op_out,
    output logic                  carry_in,
    input  cpu_pkg::byte_t        alu_result,
    input  logic                  carry_out,
    input  logic                  parity,
    // bus master
    output logic                  req,
    output logic                  req_we,
    output logic                  req_ram_sel,
    output cpu_pkg::addr_t        req_adr,
    output cpu_pkg::byte_t        req_wdata,
    input  logic                  done,
    input  cpu_pkg::byte_t        rdata
);
    import cpu_pkg::*;

    localparam logic [2:0] NOP_RELOAD = `CPU_NOP_CYCLES - 3'd1;

    cpu_state_t state;
    addr_t      pc;
    byte_t      ir, acc, b_reg, psw;
    byte_t      ram_data, rom_data;     // rom_data doubles as direct address
    byte_t      sfr_rdata;
    logic [1:0] step_cnt;
    logic [2:0] nop_cnt;
    logic       pending;                // bus request outstanding
    logic       sfr_hit, stage_end, last_step;

    function automatic byte_t pick_operand(operand_src_t src, byte_t a_v, byte_t ram_v,
                                           byte_t rom_v);
        case (src)
            SRC_ACC:      return a_v;
            SRC_RAM_DATA: return ram_v;
            SRC_ROM_DATA: return rom_v;
            default:      return '0;
        endcase
    endfunction

    assign opcode     = ir;
    assign step       = step_cnt;
    assign alu_a      = pick_operand(dst_src, acc, ram_data, rom_data);
    assign alu_b      = pick_operand(b_src, acc, ram_data, rom_data);
    assign alu_op_out = (state == ST_EXEC) ? alu_op : ALU_PASS;
    assign carry_in   = psw[`CPU_PSW_CY];

    // ----------------------------------------------------------
    // SFR decode and bus requests
    // ----------------------------------------------------------
    assign sfr_hit = (rom_data == `CPU_SFR_ACC) || (rom_data == `CPU_SFR_B) ||
                     (rom_data == `CPU_SFR_PSW);

    always_comb begin
        case (rom_data)
            `CPU_SFR_ACC: sfr_rdata = acc;
            `CPU_SFR_B:   sfr_rdata = b_reg;
            `CPU_SFR_PSW: sfr_rdata = psw;
            default:      sfr_rdata = '0;
        endcase
    end

    assign req_ram_sel = (state == ST_RAM_READ) || (state == ST_RAM_WRITE);
    assign req_we      = (state == ST_RAM_WRITE);
    assign req_adr     = req_ram_sel ? {{(`CPU_ADDR_W-`CPU_DATA_W){1'b0}}, rom_data} : pc;
    assign req_wdata   = alu_a;
    assign req = !pending && ((state == ST_FETCH) || (state == ST_ROM_READ) ||
                              (req_ram_sel && !sfr_hit));

    // a decoded step finishes, SFR accesses take a single cycle
    assign stage_end = (state == ST_EXEC) ||
                       ((state == ST_ROM_READ) && done) ||
                       (req_ram_sel && (sfr_hit || done));
    assign last_step = (step_cnt + 2'd1 == step_total);

    // ----------------------------------------------------------
    // state, PC and architectural registers
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_NOP;
            nop_cnt  <= NOP_RELOAD;
            pc       <= `CPU_RESET_PC;
            step_cnt <= 2'd0;
            pending  <= 1'b0;
            acc      <= '0;
            b_reg    <= '0;
            psw      <= '0;
        end else begin
            if (req) begin
                pending <= 1'b1;
            end else if (done) begin
                pending <= 1'b0;
            end
            case (state)
                ST_NOP: begin
                    if (nop_cnt == 3'd0) begin
                        state   <= ST_FETCH;
                        nop_cnt <= NOP_RELOAD;
                    end else begin
                        nop_cnt <= nop_cnt - 3'd1;
                    end
                end
                ST_FETCH: begin
                    if (done) begin
                        pc       <= pc + 1'b1;
                        step_cnt <= 2'd0;
                        state    <= ST_DECODE;
                    end
                end
                ST_DECODE:   state <= next_state;
                ST_ROM_READ: if (done) pc <= pc + 1'b1;
                ST_EXEC: begin
                    if (dst_src == SRC_ACC) begin
                        acc                <= alu_result;
                        psw[`CPU_PSW_CY]   <= carry_out;
                        psw[`CPU_PSW_P]    <= parity;
                    end
                end
                ST_RAM_WRITE: begin
                    if (sfr_hit) begin
                        case (rom_data)
                            `CPU_SFR_ACC: begin
                                acc             <= alu_a;
                                psw[`CPU_PSW_P] <= ^alu_a;
                            end
                            `CPU_SFR_B:   b_reg <= alu_a;
                            default: begin
                                psw             <= alu_a;
                                psw[`CPU_PSW_P] <= ^acc;    // P always follows ACC
                            end
                        endcase
                    end
                end
                default: ;
            endcase
            if (stage_end) begin
                step_cnt <= step_cnt + 2'd1;
                state    <= last_step ? ST_FETCH : ST_DECODE;
            end
        end
    end

    // instruction and operand bytes
    always_ff @(posedge clk) begin
        if ((state == ST_FETCH) && done) begin
            ir <= rdata;
        end
        if ((state == ST_ROM_READ) && done) begin
            rom_data <= rdata;
        end
        if ((state == ST_RAM_READ) && stage_end) begin
            ram_data <= sfr_hit ? sfr_rdata : rdata;
        end
        if (state == ST_EXEC) begin
            if (dst_src == SRC_RAM_DATA) ram_data <= alu_result;
            if (dst_src == SRC_ROM_DATA) rom_data <= alu_result;
        end
    end

endmodule

`default_nettype wire

// ==== design/cpu_decoder.sv ====
/*
 * Instruction decoder
 * maps opcode and step index to the next FSM stage, ALU operation,
 * operand sources and the number of steps of the instruction
 */
`timescale 1ns/100ps
`default_nettype none

module cpu_decoder (
    input  cpu_pkg::byte_t        opcode,
    input  logic [1:0]            step,        // steps already done
    output cpu_pkg::cpu_state_t   next_state,
    output logic [1:0]            step_total,
    output cpu_pkg::alu_op_t      alu_op,
    output cpu_pkg::operand_src_t a_src,       // also the destination
    output cpu_pkg::operand_src_t b_src
);
    import cpu_pkg::*;

    alu_op_t imm_op;    // operation of the immediate forms

    always_comb begin
        case (cpu_opcode_t'(opcode))
            OP_ADD_IMM, OP_ADD_DIR: imm_op = ALU_ADD;
            OP_ANL_IMM:             imm_op = ALU_ANL;
            OP_XRL_IMM:             imm_op = ALU_XRL;
            default:                imm_op = ALU_PASS;   // the MOV forms
        endcase
    end

    always_comb begin
        next_state = ST_NOP;
        step_total = 2'd0;
        alu_op     = ALU_PASS;
        a_src      = SRC_NONE;
        b_src      = SRC_NONE;
        case (cpu_opcode_t'(opcode))
            OP_NOP: next_state = ST_NOP;
            OP_INC_A: begin
                step_total = 2'd1;
                next_state = ST_EXEC;
                alu_op     = ALU_INC;
                a_src      = SRC_ACC;
            end
            // immediate byte then execute
            OP_ADD_IMM, OP_ANL_IMM, OP_XRL_IMM, OP_MOV_IMM: begin
                step_total = 2'd2;
                if (step == 2'd0) begin
                    next_state = ST_ROM_READ;
                end else begin
                    next_state = ST_EXEC;
                    alu_op     = imm_op;
                    a_src      = SRC_ACC;
                    b_src      = SRC_ROM_DATA;
                end
            end
            // direct address, RAM operand, execute
            OP_ADD_DIR, OP_MOV_A_DIR: begin
                step_total = 2'd3;
                case (step)
                    2'd0:    next_state = ST_ROM_READ;
                    2'd1:    next_state = ST_RAM_READ;
                    default: begin
                        next_state = ST_EXEC;
                        alu_op     = imm_op;
                        a_src      = SRC_ACC;
                        b_src      = SRC_RAM_DATA;
                    end
                endcase
            end
            OP_MOV_DIR_A: begin
                step_total = 2'd2;
                if (step == 2'd0) begin
                    next_state = ST_ROM_READ;
                end else begin
                    next_state = ST_RAM_WRITE;
                    a_src      = SRC_ACC;       // write data
                end
            end
            default: next_state = ST_NOP;       // unknown opcode idles
        endcase
    end

endmodule

`default_nettype wire

// ==== design/cpu_pkg.sv ====
/*
 * cpu_pkg
 * shared types for the 8051 subset core: FSM states, opcodes,
 * ALU operations, operand sources and bus word types
 */
`default_nettype none

`include "cpu_config.svh"

package cpu_pkg;

    typedef logic [`CPU_DATA_W-1:0] byte_t;
    typedef logic [`CPU_ADDR_W-1:0] addr_t;

    // instruction FSM stages
    typedef enum logic [2:0] {
        ST_NOP,
        ST_FETCH,
        ST_DECODE,
        ST_RAM_READ,
        ST_ROM_READ,
        ST_EXEC,
        ST_RAM_WRITE
    } cpu_state_t;

    // supported opcodes, anything else idles like NOP
    typedef enum logic [7:0] {
        OP_NOP       = 8'h00,
        OP_INC_A     = 8'h04,
        OP_ADD_IMM   = 8'h24,
        OP_ADD_DIR   = 8'h25,
        OP_ANL_IMM   = 8'h54,
        OP_XRL_IMM   = 8'h64,
        OP_MOV_IMM   = 8'h74,
        OP_MOV_A_DIR = 8'hE5,
        OP_MOV_DIR_A = 8'hF5
    } cpu_opcode_t;

    typedef enum logic [2:0] {
        ALU_PASS,   // result = b
        ALU_ADD,
        ALU_ANL,
        ALU_XRL,
        ALU_INC     // result = a + 1
    } alu_op_t;

    typedef enum logic [1:0] {
        SRC_ACC,
        SRC_RAM_DATA,
        SRC_ROM_DATA,
        SRC_NONE
    } operand_src_t;

endpackage

`default_nettype wire

// ==== design/cpu_top.sv ====
/*
 * 8051 subset core top level
 * control FSM, decoder, execute unit and Wishbone classic master
 */
`timescale 1ns/100ps
`default_nettype none

module cpu_top (
    input  logic           clk,
    input  logic           rst_n,
    output cpu_pkg::addr_t wb_adr,
    output cpu_pkg::byte_t wb_dat_o,
    input  cpu_pkg::byte_t wb_dat_i,
    output logic           wb_we,
    output logic           wb_cyc,
    output logic           wb_stb,
    output logic           ram_sel,
    input  logic           wb_ack
);
    import cpu_pkg::*;

    cpu_state_t   next_state;
    operand_src_t a_src, b_src;
    alu_op_t      alu_op, alu_op_exec;
    byte_t        opcode, alu_a, alu_b, alu_result;
    byte_t        req_wdata, rdata;
    addr_t        req_adr;
    logic [1:0]   step, step_total;
    logic         carry_in, carry_out, parity;
    logic         req, req_we, req_ram_sel, done;

    cpu_control u_control (
        .clk(clk), .rst_n(rst_n),
        .next_state(next_state), .step_total(step_total),
        .alu_op(alu_op), .dst_src(a_src), .b_src(b_src),
        .opcode(opcode), .step(step),
        .alu_a(alu_a), .alu_b(alu_b), .alu_op_out(alu_op_exec), .carry_in(carry_in),
        .alu_result(alu_result), .carry_out(carry_out), .parity(parity),
        .req(req), .req_we(req_we), .req_ram_sel(req_ram_sel),
        .req_adr(req_adr), .req_wdata(req_wdata),
        .done(done), .rdata(rdata)
    );

    cpu_decoder u_decoder (
        .opcode(opcode), .step(step),
        .next_state(next_state), .step_total(step_total),
        .alu_op(alu_op), .a_src(a_src), .b_src(b_src)
    );

    cpu_alu u_alu (
        .a(alu_a), .b(alu_b), .op(alu_op_exec), .carry_in(carry_in),
        .result(alu_result), .carry_out(carry_out), .parity(parity)
    );

    cpu_bus_master u_bus (
        .clk(clk), .rst_n(rst_n),
        .req(req), .req_we(req_we), .req_ram_sel(req_ram_sel),
        .req_adr(req_adr), .req_wdata(req_wdata),
        .done(done), .rdata(rdata),
        .wb_adr(wb_adr), .wb_dat_o(wb_dat_o), .wb_dat_i(wb_dat_i),
        .wb_we(wb_we), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
        .ram_sel(ram_sel), .wb_ack(wb_ack)
    );

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+design
design/cpu_pkg.sv
design/cpu_decoder.sv
design/cpu_alu.sv
design/cpu_bus_master.sv
design/cpu_control.sv
design/cpu_top.sv
tb/cpu_tb_mem.sv
tb/tb_cpu.sv

// ==== tb/cpu_tb_mem.sv ====
/*
 * Wishbone slave model for the 8051 subset core
 * 64 KB ROM and 256-byte RAM, 0 to 3 random wait states per transfer
 */
`timescale 1ns/100ps
`default_nettype none

module cpu_tb_mem (
    input  logic           clk,
    input  logic           rst_n,
    input  cpu_pkg::addr_t wb_adr,
    input  cpu_pkg::byte_t wb_dat_o,
    output cpu_pkg::byte_t wb_dat_i,
    input  logic           wb_we,
    input  logic           wb_cyc,
    input  logic           wb_stb,
    input  logic           ram_sel,
    output logic           wb_ack
);
    import cpu_pkg::*;

    localparam int unsigned MAX_WAIT = 3;

    byte_t       rom [0:65535];
    byte_t       ram [0:255];
    int unsigned wait_left;     // wait states still to insert
    logic        in_transfer;

    initial begin
        int unsigned k;
        void'($urandom(56));
        for (k = 0; k < 65536; k++) begin
            rom[k] = byte_t'(k ^ (k >> 8));     // low byte xor high byte
        end
        for (k = 0; k < 256; k++) begin
            ram[k] = byte_t'(k) ^ 8'h5A;
        end
        wb_ack      = 1'b0;
        wb_dat_i    = '0;
        in_transfer = 1'b0;
        wait_left   = 0;
        forever begin
            @(posedge clk or negedge rst_n);
            if (!rst_n) begin
                wb_ack      <= 1'b0;
                in_transfer = 1'b0;
            end else if (wb_ack) begin
                // master closes the cycle at this edge
                wb_ack      <= 1'b0;
                in_transfer = 1'b0;
                if (wb_we && ram_sel) begin
                    ram[wb_adr[7:0]] <= wb_dat_o;
                end
            end else if (wb_cyc && wb_stb) begin
                if (!in_transfer) begin
                    in_transfer = 1'b1;
                    wait_left   = $urandom % (MAX_WAIT + 1);
                end
                if (wait_left == 0) begin
                    wb_ack   <= 1'b1;
                    wb_dat_i <= ram_sel ? ram[wb_adr[7:0]] : rom[wb_adr];
                end else begin
                    wait_left--;    // back-pressure
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb/tb_cpu.sv ====
/*
 * Testbench for the 8051 subset core
 * runs directed programs from the ROM model and checks every bus transfer
 */
`timescale 1ns/100ps
`default_nettype none

`include "cpu_config.svh"

module tb_cpu;
    import cpu_pkg::*;

    localparam int unsigned GAP_LIMIT   = 40;   // idle, decode and wait states between transfers
    // about 60 transfers of at most a dozen clocks, six resets, with margin
    localparam int unsigned CYCLE_LIMIT = 2000;

    logic        clk;
    logic        rst_n;
    addr_t       wb_adr;
    byte_t       wb_dat_o, wb_dat_i;
    logic        wb_we, wb_cyc, wb_stb, ram_sel, wb_ack;
    addr_t       pc_model;      // next ROM address the core must read
    byte_t       program_q[$];
    int unsigned cycle_cnt;

    cpu_top dut0 (
        .clk(clk), .rst_n(rst_n),
        .wb_adr(wb_adr), .wb_dat_o(wb_dat_o), .wb_dat_i(wb_dat_i),
        .wb_we(wb_we), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
        .ram_sel(ram_sel), .wb_ack(wb_ack)
    );

    cpu_tb_mem mem0 (
        .clk(clk), .rst_n(rst_n),
        .wb_adr(wb_adr), .wb_dat_o(wb_dat_o), .wb_dat_i(wb_dat_i),
        .wb_we(wb_we), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
        .ram_sel(ram_sel), .wb_ack(wb_ack)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == CYCLE_LIMIT) begin
            stop_on_error("run hit the cycle limit, the core stopped making progress");
        end
    end

    // ------------------------------------------------------------
    // checks
    // ------------------------------------------------------------
    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("ERR %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("ERR %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("ERR %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // sample the next acknowledged transfer at its ack edge
    task automatic wait_transfer(output addr_t adr, output logic we, output logic sel,
                                 output byte_t wdata);
        int unsigned gap;
        gap = 0;
        do begin
            @(posedge clk);
            gap++;
            if (gap > GAP_LIMIT) begin
                stop_on_error($sformatf("no bus transfer completed within %0d cycles",
                                        GAP_LIMIT));
            end
        end while (!(wb_cyc && wb_stb && wb_ack));
        adr   = wb_adr;
        we    = wb_we;
        sel   = ram_sel;
        wdata = wb_dat_o;
    endtask

    // no cycle may start while the core idles
    task automatic expect_bus_idle(input int unsigned n);
        repeat (n) begin
            @(posedge clk);
            if (wb_cyc || wb_stb) begin
                stop_on_error("a bus cycle started while the core should be idle");
            end
        end
    endtask

    task automatic rom_reads(input int unsigned n);
        addr_t adr;
        byte_t wdata;
        logic  we, sel;
        repeat (n) begin
            wait_transfer(adr, we, sel, wdata);
            check_flag("ram_sel", sel, 1'b0);
            check_flag("wb_we", we, 1'b0);
            check_addr("wb_adr", adr, pc_model);
            pc_model = pc_model + 16'd1;
        end
    endtask

    task automatic ram_read_at(input byte_t dir);
        addr_t adr;
        byte_t wdata;
        logic  we, sel;
        wait_transfer(adr, we, sel, wdata);
        check_flag("ram_sel", sel, 1'b1);
        check_flag("wb_we", we, 1'b0);
        check_addr("wb_adr", adr, {8'h00, dir});
    endtask

    task automatic ram_write_at(input byte_t dir, input byte_t data);
        addr_t adr;
        byte_t wdata;
        logic  we, sel;
        wait_transfer(adr, we, sel, wdata);
        check_flag("ram_sel", sel, 1'b1);
        check_flag("wb_we", we, 1'b1);
        check_addr("wb_adr", adr, {8'h00, dir});
        check_byte("wb_dat_o", wdata, data);
    endtask

    // load program_q at the reset vector under reset, then release
    task automatic boot_program();
        int unsigned i;
        @(posedge clk);
        rst_n <= 1'b0;
        for (i = 0; i < program_q.size() + 8; i++) begin
            mem0.rom[`CPU_RESET_PC + i] = (i < program_q.size()) ? program_q[i] : 8'h00;
        end
        pc_model = `CPU_RESET_PC;
        repeat (3) @(posedge clk);
        check_flag("wb_cyc", wb_cyc, 1'b0);
        check_flag("wb_stb", wb_stb, 1'b0);
        check_flag("wb_we", wb_we, 1'b0);
        rst_n <= 1'b1;
    endtask

    // ------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------
    task automatic reset_and_fetch();
        program_q = '{8'h00, 8'h00, 8'h00, 8'h00};
        boot_program();
        rom_reads(5);
    endtask

    task automatic idle_opcodes();
        program_q = '{8'h00, 8'hA5, 8'h00, 8'h33};     // A5 and 33 are not kept
        boot_program();
        repeat (program_q.size()) begin
            rom_reads(1);
            expect_bus_idle(`CPU_NOP_CYCLES);   // no operand or RAM traffic
        end
        rom_reads(1);
    endtask

    task automatic mov_to_ram();
        program_q = '{8'h74, 8'h5A, 8'hF5, 8'h30};
        boot_program();
        rom_reads(4);
        ram_write_at(8'h30, 8'h5A);
        rom_reads(1);
    endtask

    task automatic immediate_alu();
        byte_t a_mov, b_add, b_anl, b_xrl;
        byte_t exp_add, exp_anl, exp_xrl, exp_inc;
        a_mov   = 8'h9C;
        b_add   = 8'h87;
        b_anl   = 8'h3E;
        b_xrl   = 8'hF0;
        exp_add = a_mov + b_add;        // wraps at 8 bits
        exp_anl = exp_add & b_anl;
        exp_xrl = exp_anl ^ b_xrl;
        exp_inc = exp_xrl + 8'd1;
        program_q = '{8'h74, a_mov, 8'h24, b_add, 8'hF5, 8'h31, 8'h54, b_anl, 8'hF5, 8'h32,
                      8'h64, b_xrl, 8'hF5, 8'h33, 8'h04, 8'hF5, 8'h34};
        boot_program();
        rom_reads(6);
        ram_write_at(8'h31, exp_add);
        rom_reads(4);
        ram_write_at(8'h32, exp_anl);
        rom_reads(4);
        ram_write_at(8'h33, exp_xrl);
        rom_reads(3);   // INC A is a single byte
        ram_write_at(8'h34, exp_inc);
        rom_reads(1);
    endtask

    task automatic direct_operands();
        byte_t d0, d1;
        d0 = 8'h6B;
        d1 = 8'hC4;
        mem0.ram[8'h20] = d0;
        mem0.ram[8'h21] = d1;
        program_q = '{8'hE5, 8'h20, 8'h25, 8'h21, 8'hF5, 8'h22};
        boot_program();
        rom_reads(2);
        ram_read_at(8'h20);
        rom_reads(2);
        ram_read_at(8'h21);
        rom_reads(2);
        ram_write_at(8'h22, byte_t'(d0 + d1));
        rom_reads(1);
    endtask

    task automatic sfr_psw_readback();
        byte_t      a_mov, b_add, acc_exp, psw_exp;
        logic [8:0] sum;
        a_mov   = 8'h7F;
        b_add   = 8'h86;
        sum     = {1'b0, a_mov} + {1'b0, b_add};
        acc_exp = sum[7:0];
        psw_exp = '0;
        psw_exp[`CPU_PSW_CY] = sum[8];
        psw_exp[`CPU_PSW_P]  = ^acc_exp;    // set for an odd count of ones
        program_q = '{8'h74, a_mov, 8'h24, b_add, 8'hF5, 8'hF0, 8'hE5, 8'hD0, 8'hF5, 8'h40};
        boot_program();
        // B and PSW accesses must not appear between the ROM reads
        rom_reads(10);
        ram_write_at(8'h40, psw_exp);
        rom_reads(1);
    endtask

    initial begin
        rst_n     = 1'b0;
        cycle_cnt = 0;
        repeat (2) @(posedge clk);
        reset_and_fetch();
        idle_opcodes();
        mov_to_ram();
        immediate_alu();
        direct_operands();
        sfr_psw_readback();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire
